// ==== tile_video.f ====
video_pkg.sv
video_timing.sv
tile_layer.sv
object_layer.sv
color_mixer.sv
tile_video.sv
tile_video_chk.sv
tile_video_tb.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the tile video generator

TOP = tile_video_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tile_video.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tile_video.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tile_video_tb.sv ====
// Testbench for the tile video generator
// Memory models, reference pixel function and frame compare tasks
`timescale 1ns/1ns

module tile_video_tb import video_pkg::*; ();

    logic                clk = 1'b0;
    logic                rst_n;
    logic                cpu_we;
    logic [cpu_aw-1:0]   cpu_addr;
    logic [cpu_dw-1:0]   cpu_dout;
    logic                map_cs;
    logic                obj_cs;
    logic                pal_cs;
    logic                prio_cs;
    logic [gfx_aw-1:0]   prog_addr;
    logic [prog_dw-1:0]  prog_data;
    logic                tile_prog_we;
    logic                obj_prog_we;
    logic                hs;
    logic                vs;
    logic                lhbl_dly;
    logic                lvbl_dly;
    logic [rgb_w-1:0]    red;
    logic [rgb_w-1:0]    green;
    logic [rgb_w-1:0]    blue;

    // Models of the DUT memories and registers
    int                tile_rom [2**gfx_aw];
    int                obj_rom  [2**gfx_aw];
    int                map_code [map_size];
    int                map_pal  [map_size];
    int                ox       [obj_count];
    int                oy       [obj_count];
    int                ocode    [obj_count];
    int                opal     [obj_count];
    int                oen      [obj_count];
    logic [pal_dw-1:0] pal      [2**pal_aw];
    bit                tile_first;

    int seed;
    int checks;
    int errors;
    int tests;
    int checks_mark;
    int errors_mark;
    bit timed_out;

    always #4 clk = ~clk;

    tile_video tile_video_i (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cpu_we       ( cpu_we       ),
        .cpu_addr     ( cpu_addr     ),
        .cpu_dout     ( cpu_dout     ),
        .map_cs       ( map_cs       ),
        .obj_cs       ( obj_cs       ),
        .pal_cs       ( pal_cs       ),
        .prio_cs      ( prio_cs      ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .tile_prog_we ( tile_prog_we ),
        .obj_prog_we  ( obj_prog_we  ),
        .hs           ( hs           ),
        .vs           ( vs           ),
        .lhbl_dly     ( lhbl_dly     ),
        .lvbl_dly     ( lvbl_dly     ),
        .red          ( red          ),
        .green        ( green        ),
        .blue         ( blue         )
    );

    // Expected colour for a visible position
    function automatic logic [pal_dw-1:0] expected_rgb(input int x, input int y);
        int idx;
        int tcol;
        int tpix;
        int opix;
        int c;
        int pidx;
        bit obj_hit;
        idx     = (y / 8) * tile_cols + x / 8;
        tcol    = tile_rom[map_code[idx] * 64 + (y % 8) * 8 + x % 8];
        tpix    = map_pal[idx] * 4 + tcol;
        obj_hit = 1'b0;
        opix    = 0;
        for (int i = 0; i < obj_count; i++) begin
            if (oen[i] != 0 && !obj_hit && x >= ox[i] && x < ox[i] + 8 &&
                y >= oy[i] && y < oy[i] + 8) begin
                c = obj_rom[ocode[i] * 64 + (y - oy[i]) * 8 + (x - ox[i])];
                if (c != 0) begin
                    obj_hit = 1'b1;
                    opix    = opal[i] * 4 + c;
                end
            end
        end
        if (tile_first) begin
            pidx = (tcol != 0) ? tpix : (obj_hit ? 16 + opix : 0);
        end else begin
            pidx = obj_hit ? 16 + opix : ((tcol != 0) ? tpix : 0);
        end
        return pal[pidx];
    endfunction

    task automatic check_rgb(input string name, input logic [pal_dw-1:0] exp,
                             input logic [pal_dw-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("Test %-10s %0d checks, %0d errors", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    task automatic cpu_write(input logic [cpu_aw-1:0] addr, input logic [cpu_dw-1:0] data,
                             input logic [3:0] sel);
        @(negedge clk);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_we   = 1'b1;
        // Select order is map, object, palette, priority
        {map_cs, obj_cs, pal_cs, prio_cs} = sel;
        @(negedge clk);
        cpu_we = 1'b0;
        {map_cs, obj_cs, pal_cs, prio_cs} = 4'b0000;
    endtask

    task automatic write_palette();
        for (int i = 0; i < 2**pal_aw; i++) begin
            pal[i] = pal_dw'($random(seed));
            cpu_write(cpu_aw'(i), pal[i], 4'b0010);
        end
    endtask

    task automatic load_memories();
        int r;
        for (int a = 0; a < 2**gfx_aw; a++) begin
            tile_rom[a] = $random(seed) & 3;
            obj_rom[a]  = $random(seed) & 3;
        end
        // Tile ROM first and object ROM after it on the same port
        for (int a = 0; a < 2 * 2**gfx_aw; a++) begin
            @(negedge clk);
            prog_addr    = gfx_aw'(a);
            tile_prog_we = a < 2**gfx_aw;
            obj_prog_we  = a >= 2**gfx_aw;
            prog_data    = prog_dw'(tile_prog_we ? tile_rom[a % 2**gfx_aw]
                                                 : obj_rom[a % 2**gfx_aw]);
        end
        @(negedge clk);
        tile_prog_we = 1'b0;
        obj_prog_we  = 1'b0;
        for (int i = 0; i < map_size; i++) begin
            r           = $random(seed);
            map_code[i] = r & 15;
            map_pal[i]  = (r >> 4) & 3;
            cpu_write(cpu_aw'(i), cpu_dw'(map_pal[i] * 16 + map_code[i]), 4'b1000);
        end
        write_palette();
    endtask

    task automatic place_objects();
        int r;
        for (int i = 0; i < obj_count; i++) begin
            r = $random(seed);
            if (i == 0) begin
                ox[i] = (r & 63) % 40;
                oy[i] = ((r >> 6) & 63) % 24;
            end else if (i == 3) begin
                ox[i] = r & 63;
                oy[i] = (r >> 6) & 63;
            end else begin
                // Objects 1 and 2 partly cover object 0
                ox[i] = ox[0] + 2 * i - 1;
                oy[i] = oy[0] + 5 - 2 * i;
            end
            ocode[i] = (r >> 12) & 15;
            opal[i]  = (r >> 16) & 3;
            oen[i]   = 1;
            cpu_write(cpu_aw'(4 * i), cpu_dw'(ox[i]), 4'b0100);
            cpu_write(cpu_aw'(4 * i + 1), cpu_dw'(oy[i]), 4'b0100);
            cpu_write(cpu_aw'(4 * i + 2), cpu_dw'(2048 + opal[i] * 16 + ocode[i]), 4'b0100);
        end
    endtask

    task automatic wait_vs_rise();
        int n;
        n = 0;
        while (vs && n < 4 * h_total * v_total) begin
            @(negedge clk);
            n++;
        end
        while (!vs && n < 4 * h_total * v_total) begin
            @(negedge clk);
            n++;
        end
        if (!vs) begin
            $display("Timeout: no vertical sync pulse within two frames");
            timed_out = 1'b1;
        end
    endtask

    // Walks one frame of output with one compare per pixel clock
    task automatic scan_frame(input string name, input bit pixels);
        int n;
        int lines;
        int halves;
        lines = 0;
        n     = 0;
        wait_vs_rise();
        while (!timed_out && !lvbl_dly && n < 2 * h_total * v_total) begin
            @(negedge clk);
            n++;
        end
        if (!timed_out && !lvbl_dly) begin
            $display("Timeout: vertical blanking did not end after sync");
            timed_out = 1'b1;
        end
        n = 0;
        while (!timed_out && lvbl_dly && n < 4 * h_total * v_total) begin
            if (lhbl_dly) begin
                halves = 0;
                while (lhbl_dly && n < 4 * h_total * v_total) begin
                    if (pixels && halves % 2 == 0 && halves / 2 < h_active &&
                        lines < v_active) begin
                        check_rgb(name, expected_rgb(halves / 2, lines), {red, green, blue});
                    end
                    halves++;
                    n++;
                    @(negedge clk);
                end
                check_count({name, " pixels per line"}, h_active, halves / 2);
                lines++;
            end else begin
                n++;
                @(negedge clk);
            end
        end
        if (!timed_out && lvbl_dly) begin
            $display("Timeout: visible area of the frame did not end");
            timed_out = 1'b1;
        end
        if (!timed_out) begin
            check_count({name, " lines per frame"}, v_active, lines);
        end
    endtask

    task automatic check_blanking();
        int blanks;
        int hs_high;
        int vs_high;
        blanks  = 0;
        hs_high = 0;
        vs_high = 0;
        wait_vs_rise();
        if (timed_out) begin
            return;
        end
        // One whole frame with every pixel seen twice
        for (int n = 0; n < 2 * h_total * v_total; n++) begin
            if (!(lhbl_dly && lvbl_dly)) begin
                blanks++;
                check_rgb("blanking", '0, {red, green, blue});
            end
            if (hs) begin
                hs_high++;
            end
            if (vs) begin
                vs_high++;
            end
            @(negedge clk);
        end
        check_count("blanking positions", h_total * v_total - h_active * v_active, blanks / 2);
        // Sync pulse widths summed over the frame
        check_count("hs pixels per frame", (hs_end - hs_start) * v_total, hs_high / 2);
        check_count("vs pixels per frame", (vs_end - vs_start) * h_total, vs_high / 2);
    endtask

    task automatic run_tests();
        load_memories();
        scan_frame("geometry", 1'b0);
        report_test("geometry");
        if (timed_out) begin
            return;
        end
        scan_frame("tiles_only", 1'b1);
        report_test("tiles_only");
        if (timed_out) begin
            return;
        end
        place_objects();
        scan_frame("obj_front", 1'b1);
        report_test("obj_front");
        if (timed_out) begin
            return;
        end
        tile_first = 1'b1;
        cpu_write('0, cpu_dw'(1), 4'b0001);
        scan_frame("tile_front", 1'b1);
        report_test("tile_front");
        if (timed_out) begin
            return;
        end
        write_palette();
        scan_frame("palette", 1'b1);
        report_test("palette");
        if (timed_out) begin
            return;
        end
        check_blanking();
        report_test("blanking");
    endtask

    initial begin
        seed         = 32'h6857;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        checks_mark  = 0;
        errors_mark  = 0;
        timed_out    = 1'b0;
        tile_first   = 1'b0;
        rst_n        = 1'b0;
        cpu_we       = 1'b0;
        cpu_addr     = '0;
        cpu_dout     = '0;
        map_cs       = 1'b0;
        obj_cs       = 1'b0;
        pal_cs       = 1'b0;
        prio_cs      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        tile_prog_we = 1'b0;
        obj_prog_we  = 1'b0;
        for (int i = 0; i < obj_count; i++) begin
            ox[i]    = 0;
            oy[i]    = 0;
            ocode[i] = 0;
            opal[i]  = 0;
            oen[i]   = 0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        run_tests();
        errors += tile_video_i.chk_i.fail_cnt;
        $display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tile_video_chk.sv ====
// Concurrent checks on pixel enable, sync placement and blanked RGB
`timescale 1ns/1ns

module tile_video_chk import video_pkg::*; (
    input logic             clk,
    input logic             rst_n,
    input logic             pxl_cen,
    input logic             lhbl,
    input logic             lvbl,
    input logic             hs,
    input logic             vs,
    input logic             lhbl_dly,
    input logic             lvbl_dly,
    input logic [rgb_w-1:0] red,
    input logic [rgb_w-1:0] green,
    input logic [rgb_w-1:0] blue
);

    int fail_cnt = 0;

    // Enable toggles on every clock once out of reset
    cen_toggle: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> pxl_cen != $past(pxl_cen))
        else begin
            fail_cnt++;
            $error("pixel enable did not alternate");
        end

    hs_in_blank: assert property (@(posedge clk) disable iff (!rst_n) hs |-> !lhbl)
        else begin
            fail_cnt++;
            $error("horizontal sync outside horizontal blanking");
        end

    vs_in_blank: assert property (@(posedge clk) disable iff (!rst_n) vs |-> !lvbl)
        else begin
            fail_cnt++;
            $error("vertical sync outside vertical blanking");
        end

    rgb_blanked: assert property (@(posedge clk) disable iff (!rst_n)
        !(lhbl_dly && lvbl_dly) |-> {red, green, blue} == '0)
        else begin
            fail_cnt++;
            $error("RGB not zero during blanking");
        end

endmodule

bind tile_video tile_video_chk chk_i (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .pxl_cen  ( pxl_cen  ),
    .lhbl     ( lhbl     ),
    .lvbl     ( lvbl     ),
    .hs       ( hs       ),
    .vs       ( vs       ),
    .lhbl_dly ( lhbl_dly ),
    .lvbl_dly ( lvbl_dly ),
    .red      ( red      ),
    .green    ( green    ),
    .blue     ( blue     )
);

// ==== tile_video.sv ====
// Tile and sprite video generator top level
// Timing, tile layer, object layer and colour mixer
`timescale 1ns/1ns

module tile_video import video_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cpu_we,
    input  logic [cpu_aw-1:0]    cpu_addr,
    input  logic [cpu_dw-1:0]    cpu_dout,
    input  logic                 map_cs,
    input  logic                 obj_cs,
    input  logic                 pal_cs,
    input  logic                 prio_cs,
    input  logic [gfx_aw-1:0]    prog_addr,
    input  logic [prog_dw-1:0]   prog_data,
    input  logic                 tile_prog_we,
    input  logic                 obj_prog_we,
    output logic                 hs,
    output logic                 vs,
    output logic                 lhbl_dly,
    output logic                 lvbl_dly,
    output logic [rgb_w-1:0]     red,
    output logic [rgb_w-1:0]     green,
    output logic [rgb_w-1:0]     blue
);

    logic                     pxl_cen;
    logic [cnt_w-1:0]         hdump;
    logic [cnt_w-1:0]         vdump;
    logic                     lhbl;
    logic                     lvbl;
    logic [layer_pixel_w-1:0] tile_pxl;
    logic [layer_pixel_w-1:0] obj_pxl;

    video_timing u_timing (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .pxl_cen    ( pxl_cen       ),
        .hdump      ( hdump         ),
        .vdump      ( vdump         ),
        .lhbl       ( lhbl          ),
        .lvbl       ( lvbl          ),
        .hs         ( hs            ),
        .vs         ( vs            )
    );

    tile_layer u_tile (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pxl_cen      ( pxl_cen      ),
        .hdump        ( hdump        ),
        .vdump        ( vdump        ),
        .cpu_we       ( cpu_we       ),
        .map_cs       ( map_cs       ),
        .cpu_addr     ( cpu_addr     ),
        .cpu_dout     ( cpu_dout     ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .tile_prog_we ( tile_prog_we ),
        .tile_pxl     ( tile_pxl     )
    );

    object_layer u_obj (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .pxl_cen     ( pxl_cen      ),
        .hdump       ( hdump        ),
        .vdump       ( vdump        ),
        .cpu_we      ( cpu_we       ),
        .obj_cs      ( obj_cs       ),
        .cpu_addr    ( cpu_addr     ),
        .cpu_dout    ( cpu_dout     ),
        .prog_addr   ( prog_addr    ),
        .prog_data   ( prog_data    ),
        .obj_prog_we ( obj_prog_we  ),
        .obj_pxl     ( obj_pxl      )
    );

    color_mixer u_colmix (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .pxl_cen    ( pxl_cen       ),
        .lhbl       ( lhbl          ),
        .lvbl       ( lvbl          ),
        .cpu_we     ( cpu_we        ),
        .pal_cs     ( pal_cs        ),
        .prio_cs    ( prio_cs       ),
        .cpu_addr   ( cpu_addr      ),
        .cpu_dout   ( cpu_dout      ),
        .tile_pxl   ( tile_pxl      ),
        .obj_pxl    ( obj_pxl       ),
        .red        ( red           ),
        .green      ( green         ),
        .blue       ( blue          ),
        .lhbl_dly   ( lhbl_dly      ),
        .lvbl_dly   ( lvbl_dly      )
    );

endmodule

// ==== color_mixer.sv ====
// Colour mixer: layer priority, palette RAM, registered RGB
// and two-stage blanking delay
`timescale 1ns/1ns

module color_mixer import video_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pxl_cen,
    input  logic                     lhbl,
    input  logic                     lvbl,
    input  logic                     cpu_we,
    input  logic                     pal_cs,
    input  logic                     prio_cs,
    input  logic [cpu_aw-1:0]        cpu_addr,
    input  logic [cpu_dw-1:0]        cpu_dout,
    input  logic [layer_pixel_w-1:0] tile_pxl,
    input  logic [layer_pixel_w-1:0] obj_pxl,
    output logic [rgb_w-1:0]         red,
    output logic [rgb_w-1:0]         green,
    output logic [rgb_w-1:0]         blue,
    output logic                     lhbl_dly,
    output logic                     lvbl_dly
);

    prio_mode_e        prio_mode;
    logic [pal_dw-1:0] pal_ram [2**pal_aw];
    logic [pal_aw-1:0] pal_idx;
    logic [pal_dw-1:0] pal_entry;
    logic              tile_opaque;
    logic              obj_opaque;
    logic              lhbl_d1;
    logic              lvbl_d1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_mode <= obj_front;
        end else if (cpu_we && prio_cs) begin
            prio_mode <= cpu_dout[0] ? tile_front : obj_front;
        end
    end

    // Palette entry is {red, green, blue}
    always_ff @(posedge clk) begin
        if (cpu_we && pal_cs) begin
            pal_ram[cpu_addr[pal_aw-1:0]] <= cpu_dout[pal_dw-1:0];
        end
    end

    assign tile_opaque = tile_pxl[col_w-1:0] != '0;
    assign obj_opaque  = obj_pxl[col_w-1:0] != '0;

    // Objects use the upper half of the palette
    always_comb begin
        pal_idx = '0;
        if (prio_mode == obj_front) begin
            if (obj_opaque) begin
                pal_idx = {1'b1, obj_pxl};
            end else if (tile_opaque) begin
                pal_idx = {1'b0, tile_pxl};
            end
        end else begin
            if (tile_opaque) begin
                pal_idx = {1'b0, tile_pxl};
            end else if (obj_opaque) begin
                pal_idx = {1'b1, obj_pxl};
            end
        end
        pal_entry = pal_ram[pal_idx];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            lhbl_d1  <= lhbl;
            lvbl_d1  <= lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            // First stage lines up with the layer pixels
            if (lhbl_d1 && lvbl_d1) begin
                {red, green, blue} <= pal_entry;
            end else begin
                {red, green, blue} <= '0;
            end
        end
    end

endmodule

// ==== object_layer.sv ====
// Object layer: four attribute sets, object graphics ROM
// and per-pixel hit test with lowest index priority
`timescale 1ns/1ns

module object_layer import video_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pxl_cen,
    input  logic [cnt_w-1:0]         hdump,
    input  logic [cnt_w-1:0]         vdump,
    input  logic                     cpu_we,
    input  logic                     obj_cs,
    input  logic [cpu_aw-1:0]        cpu_addr,
    input  logic [cpu_dw-1:0]        cpu_dout,
    input  logic [gfx_aw-1:0]        prog_addr,
    input  logic [prog_dw-1:0]       prog_data,
    input  logic                     obj_prog_we,
    output logic [layer_pixel_w-1:0] obj_pxl
);

    logic [cnt_w-1:0]  obj_x    [obj_count];
    logic [cnt_w-1:0]  obj_y    [obj_count];
    logic [code_w-1:0] obj_code [obj_count];
    logic [pal_w-1:0]  obj_pal  [obj_count];
    logic [obj_count-1:0] obj_en;
    logic [col_w-1:0]  gfx_rom  [2**gfx_aw];

    logic [obj_sel_w-1:0] wr_sel;
    logic [1:0]           wr_word;
    logic                 wr_en;

    logic [cnt_w:0]       dx      [obj_count];
    logic [cnt_w:0]       dy      [obj_count];
    logic [col_w-1:0]     obj_col [obj_count];
    logic [obj_count-1:0] hit;
    logic [layer_pixel_w-1:0] pxl_next;
    logic                 visible;

    // Address is {object, word}
    assign wr_sel  = cpu_addr[obj_sel_w+1:2];
    assign wr_word = cpu_addr[1:0];
    assign wr_en   = cpu_we && obj_cs;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obj_en <= '0;
        end else if (wr_en && wr_word == 2'd2) begin
            obj_en[wr_sel] <= cpu_dout[11];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wr_word)
                2'd0: obj_x[wr_sel] <= cpu_dout[cnt_w-1:0];
                2'd1: obj_y[wr_sel] <= cpu_dout[cnt_w-1:0];
                2'd2: begin
                    obj_code[wr_sel] <= cpu_dout[code_w-1:0];
                    obj_pal[wr_sel]  <= cpu_dout[code_w+pal_w-1:code_w];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (obj_prog_we) begin
            gfx_rom[prog_addr] <= prog_data;
        end
    end

    assign visible = hdump < cnt_w'(h_active) && vdump < cnt_w'(v_active);

    // Extra top bit keeps positions left of or above an object out of range
    always_comb begin
        for (int i = 0; i < obj_count; i++) begin
            dx[i]      = {1'b0, hdump} - {1'b0, obj_x[i]};
            dy[i]      = {1'b0, vdump} - {1'b0, obj_y[i]};
            hit[i]     = obj_en[i] && dx[i][cnt_w:3] == '0 && dy[i][cnt_w:3] == '0;
            obj_col[i] = gfx_rom[{obj_code[i], dy[i][2:0], dx[i][2:0]}];
        end
    end

    // Scan from the top index down so the lowest opaque object is kept
    always_comb begin
        pxl_next = '0;
        for (int i = obj_count - 1; i >= 0; i--) begin
            if (hit[i] && obj_col[i] != '0) begin
                pxl_next = {obj_pal[i], obj_col[i]};
            end
        end
        if (!visible) begin
            pxl_next = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obj_pxl <= '0;
        end else if (pxl_cen) begin
            obj_pxl <= pxl_next;
        end
    end

endmodule

// ==== tile_layer.sv ====
// Background tile layer: tile map RAM, tile graphics ROM
// and per-pixel colour lookup
`timescale 1ns/1ns

module tile_layer import video_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pxl_cen,
    input  logic [cnt_w-1:0]         hdump,
    input  logic [cnt_w-1:0]         vdump,
    input  logic                     cpu_we,
    input  logic                     map_cs,
    input  logic [cpu_aw-1:0]        cpu_addr,
    input  logic [cpu_dw-1:0]        cpu_dout,
    input  logic [gfx_aw-1:0]        prog_addr,
    input  logic [prog_dw-1:0]       prog_data,
    input  logic                     tile_prog_we,
    output logic [layer_pixel_w-1:0] tile_pxl
);

    // Map entry is code in [3:0], palette in [5:4]
    logic [code_w-1:0] map_code [map_size];
    logic [pal_w-1:0]  map_pal  [map_size];
    logic [col_w-1:0]  gfx_rom  [2**gfx_aw];

    logic [map_aw-1:0] map_idx;
    logic [code_w-1:0] cur_code;
    logic [pal_w-1:0]  cur_pal;
    logic [gfx_aw-1:0] gfx_addr;
    logic [col_w-1:0]  cur_col;
    logic              visible;

    always_ff @(posedge clk) begin
        if (cpu_we && map_cs && cpu_addr[map_aw-1:0] < map_aw'(map_size)) begin
            map_code[cpu_addr[map_aw-1:0]] <= cpu_dout[code_w-1:0];
            map_pal[cpu_addr[map_aw-1:0]]  <= cpu_dout[code_w+pal_w-1:code_w];
        end
    end

    // ROM loading from the programming port
    always_ff @(posedge clk) begin
        if (tile_prog_we) begin
            gfx_rom[prog_addr] <= prog_data;
        end
    end

    assign visible = hdump < cnt_w'(h_active) && vdump < cnt_w'(v_active);

    // Tile row from vdump[4:3], tile column from hdump[5:3]
    always_comb begin
        map_idx  = map_aw'(vdump[4:3]) * map_aw'(tile_cols) + map_aw'(hdump[5:3]);
        cur_code = '0;
        cur_pal  = '0;
        if (visible) begin
            cur_code = map_code[map_idx];
            cur_pal  = map_pal[map_idx];
        end
        gfx_addr = {cur_code, vdump[2:0], hdump[2:0]};
        cur_col  = gfx_rom[gfx_addr];
    end

    // Pixel for the current counters, seen one pixel later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tile_pxl <= '0;
        end else if (pxl_cen) begin
            if (visible) begin
                tile_pxl <= {cur_pal, cur_col};
            end else begin
                tile_pxl <= '0;
            end
        end
    end

endmodule

// ==== video_timing.sv ====
// Pixel clock enable, horizontal and vertical raster counters
// Registered blanking and sync decode
`timescale 1ns/1ns

module video_timing import video_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    output logic             pxl_cen,
    output logic [cnt_w-1:0] hdump,
    output logic [cnt_w-1:0] vdump,
    output logic             lhbl,
    output logic             lvbl,
    output logic             hs,
    output logic             vs
);

    logic [cnt_w-1:0] h_next;
    logic [cnt_w-1:0] v_next;

    // Pixel enable on every other clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    always_comb begin
        h_next = hdump + 1'b1;
        v_next = vdump;
        if (hdump == cnt_w'(h_total - 1)) begin
            h_next = '0;
            if (vdump == cnt_w'(v_total - 1)) begin
                v_next = '0;
            end else begin
                v_next = vdump + 1'b1;
            end
        end
    end

    // Blanking and sync decoded from the next count so they line up
    // with hdump/vdump after the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= '0;
            vdump <= '0;
            lhbl  <= 1'b1;
            lvbl  <= 1'b1;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_next;
            vdump <= v_next;
            lhbl  <= h_next < cnt_w'(h_active);
            lvbl  <= v_next < cnt_w'(v_active);
            hs    <= h_next >= cnt_w'(hs_start) && h_next < cnt_w'(hs_end);
            vs    <= v_next >= cnt_w'(vs_start) && v_next < cnt_w'(vs_end);
        end
    end

endmodule

// ==== video_pkg.sv ====
// Raster geometry, memory sizes and pixel widths for the tile video generator
// Layer priority modes
package video_pkg;

    // Raster counters
    localparam int cnt_w    = 6;
    localparam int h_total  = 64;
    localparam int h_active = 48;
    localparam int v_total  = 40;
    localparam int v_active = 32;

    // Sync pulses, both inside blanking
    localparam int hs_start = 52;
    localparam int hs_end   = 56;
    localparam int vs_start = 34;
    localparam int vs_end   = 36;

    // Tile map, 8x8 pixel tiles
    localparam int tile_cols = 6;
    localparam int tile_rows = 4;
    localparam int map_size  = tile_cols * tile_rows;
    localparam int map_aw    = 5;

    // Graphics ROMs hold {code, row, col}
    localparam int gfx_aw = 10;
    localparam int code_w = 4;
    localparam int pal_w  = 2;
    localparam int col_w  = 2;

    localparam int obj_count = 4;
    localparam int obj_sel_w = $clog2(obj_count);

    // Layer pixel is {palette, colour}, colour 0 is transparent
    localparam int layer_pixel_w = pal_w + col_w;
    localparam int pal_aw        = 5;
    localparam int rgb_w         = 4;
    localparam int pal_dw        = 3 * rgb_w;

    // CPU and programming port widths
    localparam int cpu_aw  = 8;
    localparam int cpu_dw  = 12;
    localparam int prog_dw = 2;

    typedef enum logic {
        obj_front,
        tile_front
    } prio_mode_e;

endpackage
